//--- source/rv_core_pkg.sv
package rv_core_pkg;

    // Basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] instr_t;

    // Major opcodes handled by the core, real RV32I encodings
    typedef enum logic [6:0] {
        op_none = 7'b0000000,
        op_imm  = 7'b0010011,
        op_reg  = 7'b0110011,
        lui     = 7'b0110111
    } opcode_t;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        // Second operand straight through, for LUI
        alu_pass_b
    } alu_op_t;

    // Instruction memory request
    typedef struct packed {
        logic  valid;
        word_t addr;
    } inst_req_t;

    // Instruction memory response, one cycle after the request
    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
    } inst_rsp_t;

    // Fetch to decode
    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } fetched_instr_t;

    // Decode to execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        // Low for x0 targets and unsupported opcodes
        logic     wb_enable;
        logic     use_imm;
        word_t    imm;
        alu_op_t  alu_op;
        // Operands as read from the register file at decode
        word_t    rd1;
        word_t    rd2;
    } decoded_instr_t;

    // Retired instruction, also the register file write port
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
    } retired_instr_t;

endpackage

//--- source/fetch_unit.sv
module fetch_unit #(
    parameter rv_core_pkg::word_t reset_pc = 32'h0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        inst_ready,
    output rv_core_pkg::inst_req_t      inst_req,
    input  rv_core_pkg::inst_rsp_t      inst_rsp,
    output rv_core_pkg::fetched_instr_t fetched
);

    rv_core_pkg::word_t pc;
    // Address of the request still waiting for its response
    rv_core_pkg::word_t expected_addr;

    // One request per cycle whenever the memory is ready
    always_comb begin
        inst_req.valid = inst_ready && !reset;
        inst_req.addr = pc;
    end

    // Response goes straight on to decode
    always_comb begin
        fetched.valid = inst_rsp.valid;
        fetched.pc = inst_rsp.addr;
        fetched.instr = inst_rsp.data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (inst_req.valid) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_req.valid) begin
            expected_addr <= pc;
        end
    end

    // Memory must answer with the address that was asked for
    rsp_addr_match: assert property (
        @(posedge clk) disable iff (reset)
        inst_rsp.valid |-> (inst_rsp.addr == expected_addr)
    ) else $error("fetch: response addr %h, expected %h", inst_rsp.addr, expected_addr);

endmodule

//--- source/register_file.sv
module register_file (
    input  logic                        clk,
    input  logic                        reset,
    input  rv_core_pkg::reg_idx_t       rs1,
    input  rv_core_pkg::reg_idx_t       rs2,
    output rv_core_pkg::word_t          rd1,
    output rv_core_pkg::word_t          rd2,
    input  rv_core_pkg::retired_instr_t write
);

    // x0 has no storage
    rv_core_pkg::word_t regs [1:31];

    logic write_en;

    assign write_en = write.valid && (write.rd != 5'd0);

    // Write-through so a read in the write cycle sees the new value
    always_comb begin
        if (rs1 == 5'd0) begin
            rd1 = '0;
        end else if (write_en && write.rd == rs1) begin
            rd1 = write.value;
        end else begin
            rd1 = regs[rs1];
        end
        if (rs2 == 5'd0) begin
            rd2 = '0;
        end else if (write_en && write.rd == rs2) begin
            rd2 = write.value;
        end else begin
            rd2 = regs[rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write.rd] <= write.value;
        end
    end

    // Decode drops wb_enable for x0, so a write there means a broken pipe
    no_x0_write: assert property (
        @(posedge clk) disable iff (reset)
        write.valid |-> (write.rd != 5'd0)
    ) else $error("register_file: write to x0 from pc %h", write.pc);

endmodule

//--- source/decode_stage.sv
module decode_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  rv_core_pkg::fetched_instr_t fetched,
    output rv_core_pkg::reg_idx_t       rs1,
    output rv_core_pkg::reg_idx_t       rs2,
    input  rv_core_pkg::word_t          rd1,
    input  rv_core_pkg::word_t          rd2,
    output rv_core_pkg::decoded_instr_t decoded
);

    rv_core_pkg::opcode_t        opcode;
    rv_core_pkg::reg_idx_t       rd;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    rv_core_pkg::decoded_instr_t decoded_next;

    // Register fields
    assign rs1 = fetched.instr[19:15];
    assign rs2 = fetched.instr[24:20];
    assign rd = fetched.instr[11:7];
    assign funct3 = fetched.instr[14:12];
    assign funct7 = fetched.instr[31:25];

    always_comb begin
        case (fetched.instr[6:0])
            rv_core_pkg::op_imm: opcode = rv_core_pkg::op_imm;
            rv_core_pkg::op_reg: opcode = rv_core_pkg::op_reg;
            rv_core_pkg::lui:    opcode = rv_core_pkg::lui;
            default:             opcode = rv_core_pkg::op_none;
        endcase
    end

    always_comb begin
        decoded_next.valid = fetched.valid;
        decoded_next.pc = fetched.pc;
        decoded_next.rs1 = rs1;
        decoded_next.rs2 = rs2;
        decoded_next.rd = rd;
        decoded_next.wb_enable = (opcode != rv_core_pkg::op_none) && (rd != 5'd0);
        decoded_next.use_imm = (opcode != rv_core_pkg::op_reg);
        decoded_next.rd1 = rd1;
        decoded_next.rd2 = rd2;

        // I-type immediate unless LUI
        if (opcode == rv_core_pkg::lui) begin
            decoded_next.imm = {fetched.instr[31:12], 12'd0};
        end else begin
            decoded_next.imm = {{20{fetched.instr[31]}}, fetched.instr[31:20]};
        end

        case (funct3)
            3'b000: begin
                if (opcode == rv_core_pkg::op_reg && funct7[5]) begin
                    decoded_next.alu_op = rv_core_pkg::alu_sub;
                end else begin
                    decoded_next.alu_op = rv_core_pkg::alu_add;
                end
            end
            3'b001: decoded_next.alu_op = rv_core_pkg::alu_sll;
            3'b010: decoded_next.alu_op = rv_core_pkg::alu_slt;
            3'b011: decoded_next.alu_op = rv_core_pkg::alu_sltu;
            3'b100: decoded_next.alu_op = rv_core_pkg::alu_xor;
            // SRA and SRAI both flag funct7 bit 5
            3'b101: begin
                if (funct7[5]) begin
                    decoded_next.alu_op = rv_core_pkg::alu_sra;
                end else begin
                    decoded_next.alu_op = rv_core_pkg::alu_srl;
                end
            end
            3'b110: decoded_next.alu_op = rv_core_pkg::alu_or;
            default: decoded_next.alu_op = rv_core_pkg::alu_and;
        endcase
        if (opcode == rv_core_pkg::lui) begin
            decoded_next.alu_op = rv_core_pkg::alu_pass_b;
        end
    end

    always_ff @(posedge clk) begin
        decoded <= decoded_next;
        if (reset) begin
            decoded.valid <= 1'b0;
        end
    end

endmodule

//--- source/alu.sv
module alu (
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    input  rv_core_pkg::alu_op_t op,
    output rv_core_pkg::word_t   result
);

    logic [4:0] shamt;

    // Only the low five bits shift on RV32
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_core_pkg::alu_add: begin
                result = a + b;
            end
            rv_core_pkg::alu_sub: begin
                result = a - b;
            end
            rv_core_pkg::alu_sll: begin
                result = a << shamt;
            end
            rv_core_pkg::alu_slt: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            rv_core_pkg::alu_sltu: begin
                result = {31'd0, a < b};
            end
            rv_core_pkg::alu_xor: begin
                result = a ^ b;
            end
            rv_core_pkg::alu_srl: begin
                result = a >> shamt;
            end
            rv_core_pkg::alu_sra: begin
                result = $signed(a) >>> shamt;
            end
            rv_core_pkg::alu_or: begin
                result = a | b;
            end
            rv_core_pkg::alu_and: begin
                result = a & b;
            end
            rv_core_pkg::alu_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- source/execute_stage.sv
module execute_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  rv_core_pkg::decoded_instr_t decoded,
    output rv_core_pkg::retired_instr_t retire
);

    rv_core_pkg::word_t src_a;
    rv_core_pkg::word_t src_b_reg;
    rv_core_pkg::word_t src_b;
    rv_core_pkg::word_t alu_result;

    // Result of the instruction one ahead is not yet in the register file
    // when this one read its operands
    always_comb begin
        if (retire.valid && retire.rd == decoded.rs1) begin
            src_a = retire.value;
        end else begin
            src_a = decoded.rd1;
        end
        if (retire.valid && retire.rd == decoded.rs2) begin
            src_b_reg = retire.value;
        end else begin
            src_b_reg = decoded.rd2;
        end
    end

    assign src_b = decoded.use_imm ? decoded.imm : src_b_reg;

    alu alu_inst (
        .a      (src_a),
        .b      (src_b),
        .op     (decoded.alu_op),
        .result (alu_result)
    );

    // Retire register, bubbles and x0 targets leave valid low
    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= decoded.valid && decoded.wb_enable;
        end
    end

    always_ff @(posedge clk) begin
        retire.pc <= decoded.pc;
        retire.rd <= decoded.rd;
        retire.value <= alu_result;
    end

    // Forwarding relies on retire never naming x0
    retire_not_x0: assert property (
        @(posedge clk) disable iff (reset)
        retire.valid |-> (retire.rd != 5'd0)
    ) else $error("execute: retire to x0 at pc %h", retire.pc);

endmodule

//--- source/rv_core.sv
module rv_core #(
    parameter rv_core_pkg::word_t reset_pc = 32'h0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        inst_ready,
    output rv_core_pkg::inst_req_t      inst_req,
    input  rv_core_pkg::inst_rsp_t      inst_rsp,
    output rv_core_pkg::retired_instr_t retire
);

    rv_core_pkg::fetched_instr_t fetched;
    rv_core_pkg::decoded_instr_t decoded;
    rv_core_pkg::reg_idx_t       rs1;
    rv_core_pkg::reg_idx_t       rs2;
    rv_core_pkg::word_t          rd1;
    rv_core_pkg::word_t          rd2;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_inst (
        .clk        (clk),
        .reset      (reset),
        .inst_ready (inst_ready),
        .inst_req   (inst_req),
        .inst_rsp   (inst_rsp),
        .fetched    (fetched)
    );

    // Written from the retire register
    register_file regfile_inst (
        .clk   (clk),
        .reset (reset),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd1   (rd1),
        .rd2   (rd2),
        .write (retire)
    );

    decode_stage decode_inst (
        .clk     (clk),
        .reset   (reset),
        .fetched (fetched),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd1     (rd1),
        .rd2     (rd2),
        .decoded (decoded)
    );

    execute_stage execute_inst (
        .clk     (clk),
        .reset   (reset),
        .decoded (decoded),
        .retire  (retire)
    );

endmodule

//--- testbench/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Effect of one instruction on the architectural state
typedef struct packed {
    logic        writes;
    logic [4:0]  rd;
    logic [31:0] value;
} model_result_t;

// x0 is never written, so it keeps reading zero
logic [31:0] model_regs [0:31];

// funct3 picks the operation, alt is instruction bit 30
function automatic logic [31:0] alu_model(
    input logic [2:0]  funct3,
    input logic        alt,
    input logic [31:0] a,
    input logic [31:0] b
);
    logic [31:0] r;
    case (funct3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        // Signs differ, so the negative one is smaller
        3'd2: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        3'd3: r = {31'd0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            r = a >> b[4:0];
            if (alt && a[31]) begin
                r = r | ~(32'hffff_ffff >> b[4:0]);
            end
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// Executes one instruction and updates the model registers
function automatic model_result_t step_model(input logic [31:0] instr);
    model_result_t res;
    logic [31:0]   a;
    logic [31:0]   b;
    logic [31:0]   imm;
    a = model_regs[instr[19:15]];
    b = model_regs[instr[24:20]];
    imm = {{20{instr[31]}}, instr[31:20]};
    res.rd = instr[11:7];
    res.writes = (instr[11:7] != 5'd0);
    case (instr[6:0])
        7'h13: res.value = alu_model(instr[14:12], instr[14:12] == 3'd5 && instr[30], a, imm);
        7'h33: res.value = alu_model(instr[14:12], instr[30], a, b);
        7'h37: res.value = {instr[31:12], 12'h000};
        default: begin
            res.writes = 1'b0;
            res.value = '0;
        end
    endcase
    if (res.writes) begin
        model_regs[res.rd] = res.value;
    end
    return res;
endfunction

`endif

//--- testbench/rv_core_tb.sv
module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 20;
    localparam int prog_len = 512;
    localparam rv_core_pkg::word_t reset_pc_value = 32'h0000_0100;

    // One expected retirement and the cycle it is due in
    typedef struct packed {
        rv_core_pkg::word_t    pc;
        rv_core_pkg::reg_idx_t rd;
        rv_core_pkg::word_t    value;
        int                    due;
    } expect_t;

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        inst_ready;
    rv_core_pkg::inst_req_t      inst_req;
    rv_core_pkg::inst_rsp_t      inst_rsp;
    rv_core_pkg::retired_instr_t retire;

    integer              seed;
    rv_core_pkg::instr_t prog_mem [0:prog_len-1];
    expect_t             expect_q [$];
    rv_core_pkg::word_t  next_addr;
    int                  cycle;
    int                  accepted;
    int                  retired;
    int                  skipped;
    int                  checks;
    int                  errors;
    int                  test_start;

    `include "rv_ref_model.svh"

    rv_core #(
        .reset_pc (reset_pc_value)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .inst_ready (inst_ready),
        .inst_req   (inst_req),
        .inst_rsp   (inst_rsp),
        .retire     (retire)
    );

    always #(clk_period / 2) clk = ~clk;

    // Registers only from x0 to x7 so results are reused often
    task automatic build_program();
        logic [31:0] r;
        logic [31:0] f;
        logic [2:0]  f3;
        logic [6:0]  bad_op;
        logic        alt;
        for (int i = 0; i < prog_len; i++) begin
            r = $random(seed);
            f = $random(seed);
            f3 = r[11:9];
            if (r[15:12] == 4'd0) begin
                // Load, store, branch and jal are not supported
                case (r[17:16])
                    2'd0: bad_op = 7'h03;
                    2'd1: bad_op = 7'h23;
                    2'd2: bad_op = 7'h63;
                    default: bad_op = 7'h6f;
                endcase
                prog_mem[i[8:0]] = {f[31:7], bad_op};
            end else if (r[15:12] < 4'd7) begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    alt = (f3 == 3'd5) && f[5];
                    prog_mem[i[8:0]] = {1'b0, alt, 5'd0, f[4:0], 2'b00, r[5:3], f3,
                                        2'b00, r[2:0], 7'h13};
                end else begin
                    prog_mem[i[8:0]] = {f[11:0], 2'b00, r[5:3], f3, 2'b00, r[2:0], 7'h13};
                end
            end else if (r[15:12] < 4'd13) begin
                alt = (f3 == 3'd0 || f3 == 3'd5) && f[0];
                prog_mem[i[8:0]] = {1'b0, alt, 5'd0, 2'b00, r[8:6], 2'b00, r[5:3], f3,
                                    2'b00, r[2:0], 7'h33};
            end else begin
                prog_mem[i[8:0]] = {f[19:0], 2'b00, r[2:0], 7'h37};
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before, input string detail);
        $display("test %-15s %s, %0d errors", name, detail, errors - errors_before);
    endtask

    // Memory model, retire checker and inst_ready driver
    always @(posedge clk) begin
        logic [31:0]   r;
        logic [31:0]   offset;
        logic [31:0]   word;
        model_result_t res;
        expect_t       entry;
        cycle++;
        if (reset) begin
            checks++;
            if (inst_req.valid !== 1'b0) begin
                errors++;
                $display("[FAIL] inst_req.valid: got %h, expected 0", inst_req.valid);
            end
            if (cycle > 1 && retire.valid !== 1'b0) begin
                errors++;
                $display("[FAIL] retire.valid: got %h, expected 0", retire.valid);
            end
        end else begin
            if (retire.valid === 1'b1) begin
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("Retirement of pc %h in cycle %0d was not expected", retire.pc, cycle);
                end else begin
                    entry = expect_q.pop_front();
                    retired++;
                    checks++;
                    if (retire.pc !== entry.pc) begin
                        errors++;
                        $display("[FAIL] retire.pc: got %h, expected %h", retire.pc, entry.pc);
                    end
                    if (retire.rd !== entry.rd) begin
                        errors++;
                        $display("[FAIL] retire.rd: got %h, expected %h", retire.rd, entry.rd);
                    end
                    if (retire.value !== entry.value) begin
                        errors++;
                        $display("[FAIL] retire.value: got %h, expected %h",
                                 retire.value, entry.value);
                    end
                    if (cycle != entry.due) begin
                        errors++;
                        $display("Pc %h retired in cycle %0d instead of cycle %0d",
                                 entry.pc, cycle, entry.due);
                    end
                end
            end else if (retire.valid !== 1'b0) begin
                errors++;
                $display("retire.valid is unknown in cycle %0d", cycle);
            end else if (expect_q.size() != 0 && expect_q[0].due <= cycle) begin
                entry = expect_q.pop_front();
                errors++;
                $display("Pc %h did not retire in cycle %0d", entry.pc, entry.due);
            end

            // A request goes out exactly when the memory is ready
            checks++;
            if (inst_req.valid !== inst_ready) begin
                errors++;
                $display("[FAIL] inst_req.valid: got %h, expected %h",
                         inst_req.valid, inst_ready);
            end

            // Answer arrives in the next cycle
            if (inst_req.valid === 1'b1) begin
                checks++;
                if (inst_req.addr !== next_addr) begin
                    errors++;
                    $display("[FAIL] inst_req.addr: got %h, expected %h", inst_req.addr, next_addr);
                end
                next_addr += 32'd4;
                offset = inst_req.addr - reset_pc_value;
                if (offset[1:0] != 2'b00 || offset >= prog_len * 4) begin
                    errors++;
                    $display("Request at %h lies outside the program", inst_req.addr);
                    word = '0;
                end else begin
                    word = prog_mem[offset[10:2]];
                end
                inst_rsp <= {1'b1, inst_req.addr, word};
                accepted++;
                res = step_model(word);
                if (res.writes) begin
                    entry.pc = inst_req.addr;
                    entry.rd = res.rd;
                    entry.value = res.value;
                    entry.due = cycle + 3;
                    expect_q.push_back(entry);
                end else begin
                    skipped++;
                end
            end else begin
                inst_rsp.valid <= 1'b0;
            end
        end
        // Busy about a quarter of the time, idle once the program is fetched
        r = $random(seed);
        inst_ready <= (accepted < prog_len) && (r[1:0] != 2'b00);
    end

    initial begin
        seed = 27;
        cycle = 0;
        accepted = 0;
        retired = 0;
        skipped = 0;
        checks = 0;
        errors = 0;
        next_addr = reset_pc_value;
        model_regs = '{default: '0};
        build_program();
        reset = 1'b1;
        inst_ready = 1'b0;
        inst_rsp = '0;

        test_start = errors;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (accepted == 0) @(negedge clk);
        report_test("reset", test_start, $sformatf("first request at %h", reset_pc_value));

        test_start = errors;
        while (accepted < prog_len || expect_q.size() != 0) @(negedge clk);
        report_test("random_program", test_start,
                    $sformatf("%0d requests, %0d retired", accepted, retired));

        // Idle cycles where nothing may retire
        test_start = errors;
        repeat (8) @(negedge clk);
        checks++;
        if (retired + skipped != prog_len) begin
            errors++;
            $display("Retired %0d and skipped %0d instructions out of %0d",
                     retired, skipped, prog_len);
        end
        report_test("bubbles", test_start, $sformatf("%0d without a write", skipped));

        $display("Tests: 3, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Four cycles per instruction is far more than ready gaps can cost
    initial begin
        #((prog_len * 4 + 100) * clk_period);
        $display("Timeout after %0d cycles with %0d requests accepted", cycle, accepted);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- project.f
+incdir+testbench
source/rv_core_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/alu.sv
source/execute_stage.sv
source/rv_core.sv
testbench/rv_core_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rv_core_tb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD) $(LOG)
